/* router_defs.svh */
// width and depth macros for the ipv4 forwarding pipeline
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// stream geometry
////////////////////////////////////////////////////////////////////////////

// bytes per beat, byte 0 in the low bits of data
`define ROUTER_BEAT_BYTES 8

// width of an ingress or egress port number
`define ROUTER_PORT_BITS 2

////////////////////////////////////////////////////////////////////////////
// buffer sizes
////////////////////////////////////////////////////////////////////////////

// beat buffer holds a packet while its verdict is formed
`define ROUTER_BEAT_DEPTH 16

// one verdict per packet in flight
`define ROUTER_VERDICT_DEPTH 4

`endif

/* router_pkg.sv */
// beat, metadata, ipv4 header and verdict types
`include "router_defs.svh"

package router_pkg;

    ////////////////////////////////////////////////////////////////////////
    // stream types
    ////////////////////////////////////////////////////////////////////////

    typedef logic [`ROUTER_PORT_BITS-1:0] port_t;
    typedef logic [8*`ROUTER_BEAT_BYTES-1:0] data_t;

    // only ingress_port is meaningful on the input stream
    typedef struct packed {
        port_t ingress_port;
        port_t egress_port;
    } meta_t;

    typedef struct packed {
        data_t                         data;
        logic [`ROUTER_BEAT_BYTES-1:0] keep;
        logic                          last;
        meta_t                         meta;
    } beat_t;

    ////////////////////////////////////////////////////////////////////////
    // ipv4 header, first byte on the wire in the top bits
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ipv4_hdr_t;

    // words view for the checksum, w[9] is the first word on the wire
    typedef union packed {
        ipv4_hdr_t        f;
        logic [9:0][15:0] w;
    } ipv4_hdr_u;

    ////////////////////////////////////////////////////////////////////////
    // per packet verdict
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        V_FORWARD,
        V_PASS,
        V_DROP_CSUM,
        V_DROP_TTL
    } verdict_e;

    typedef struct packed {
        verdict_e    kind;
        logic [7:0]  old_ttl;
        logic [15:0] hdr_checksum;
        port_t       egress_port;
    } verdict_t;

endpackage

/* ipv4_header_extract.sv */
// header extractor: gathers the ipv4 header, checks it, forms one verdict
// per packet and registers every beat toward the beat buffer
`timescale 1ns/1ns

module ipv4_header_extract import router_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  beat_t    in_beat,
    output logic     beat_wr_en,
    output beat_t    beat_wr_data,
    output logic     verdict_wr_en,
    output verdict_t verdict_wr_data
);

    ////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////

    // beat byte 0 goes to the top so it lines up with the header union
    function automatic data_t to_net_order(data_t d);
        data_t r;
        for (int i = 0; i < $bits(data_t) / 8; i++) begin
            r[$bits(data_t) - 8 * (i + 1) +: 8] = d[8 * i +: 8];
        end
        return r;
    endfunction

    // ones' complement sum over all ten words, carries folded back in
    function automatic logic [15:0] ones_sum(ipv4_hdr_u h);
        logic [19:0] acc;
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + {4'b0, h.w[i]};
        end
        acc = {4'b0, acc[15:0]} + {16'b0, acc[19:16]};
        acc = {4'b0, acc[15:0]} + {16'b0, acc[19:16]};
        return acc[15:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // beat counting and header capture
    ////////////////////////////////////////////////////////////////////////

    // beat index within the packet, parks at 3 past the header
    logic [1:0] beat_cnt;
    // set when the packet ended before the third beat
    logic       short_q;
    ipv4_hdr_u  hdr;
    data_t      in_net;
    logic       hdr_ok;
    logic       csum_ok;

    assign in_net = to_net_order(in_beat.data);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt      <= '0;
            short_q       <= 1'b0;
            beat_wr_en    <= 1'b0;
            verdict_wr_en <= 1'b0;
        end else begin
            beat_wr_en    <= in_valid;
            verdict_wr_en <= 1'b0;
            if (in_valid) begin
                if (in_beat.last) begin
                    beat_cnt <= '0;
                end else if (beat_cnt != 2'd3) begin
                    beat_cnt <= beat_cnt + 2'd1;
                end
                // third beat completes the header, or the packet is short
                verdict_wr_en <= (beat_cnt == 2'd2) || (in_beat.last && beat_cnt < 2'd2);
                short_q       <= in_beat.last && beat_cnt < 2'd2;
            end
        end
    end

    // header bytes 0..19 land across beats 0, 1 and the top of beat 2
    always_ff @(posedge clk) begin
        if (in_valid) begin
            beat_wr_data <= in_beat;
            case (beat_cnt)
                2'd0:    hdr.w[9:6] <= in_net;
                2'd1:    hdr.w[5:2] <= in_net;
                2'd2:    hdr.w[1:0] <= in_net[63:32];
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // verdict
    ////////////////////////////////////////////////////////////////////////

    assign hdr_ok  = !short_q && hdr.f.version == 4'd4 && hdr.f.ihl == 4'd5;
    // a correct header sums to all ones
    assign csum_ok = ones_sum(hdr) == 16'hffff;

    always_comb begin
        verdict_wr_data.old_ttl      = hdr.f.ttl;
        verdict_wr_data.hdr_checksum = hdr.f.checksum;
        verdict_wr_data.egress_port  = port_t'(hdr.f.dst_addr[7:0]);
        if (!hdr_ok) begin
            verdict_wr_data.kind        = V_PASS;
            // host port
            verdict_wr_data.egress_port = '0;
        end else if (!csum_ok) begin
            verdict_wr_data.kind = V_DROP_CSUM;
        end else if (hdr.f.ttl < 8'd2) begin
            verdict_wr_data.kind = V_DROP_TTL;
        end else begin
            verdict_wr_data.kind = V_FORWARD;
        end
    end

    // once a verdict is out, none until the packet's last beat is written
    assert property (@(posedge clk) disable iff (!arst_n)
        (verdict_wr_en && !(beat_wr_en && beat_wr_data.last)) |=>
            (!verdict_wr_en until_with (beat_wr_en && beat_wr_data.last)));

endmodule

/* beat_fifo.sv */
// circular buffer of packed words with empty, full and sticky overflow
`timescale 1ns/1ns

module beat_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty,
    output logic             full,
    output logic             overflow
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             wr_ok;
    logic             rd_ok;

    // a write into a full buffer is lost
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    assign empty = count == '0;
    assign full  = count == (AW + 1)'(DEPTH);

    // head of the buffer, valid whenever not empty
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // sticky until reset
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // the reader checks empty before it pops
    assert property (@(posedge clk) disable iff (!arst_n) rd_en |-> !empty);

endmodule

/* ipv4_forward.sv */
// forwarder: pairs each verdict with its buffered beats, drops or rewrites
// ttl and checksum, and sets the egress metadata
`timescale 1ns/1ns

module ipv4_forward import router_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  beat_t    beat_rd_data,
    input  logic     beat_empty,
    input  verdict_t verdict_rd_data,
    input  logic     verdict_empty,
    output logic     beat_rd_en,
    output logic     verdict_rd_en,
    output logic     out_valid,
    output beat_t    out_beat,
    output logic     drop_csum,
    output logic     drop_ttl
);

    ////////////////////////////////////////////////////////////////////////
    // incremental checksum, HC' = ~(~HC + ~m + m')
    ////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] csum_update(
        logic [15:0] hc,
        logic [15:0] m_old,
        logic [15:0] m_new
    );
        logic [17:0] s;
        s = {2'b0, ~hc} + {2'b0, ~m_old} + {2'b0, m_new};
        // end-around carry, twice covers the worst case
        s = {2'b0, s[15:0]} + {16'b0, s[17:16]};
        s = {2'b0, s[15:0]} + {16'b0, s[17:16]};
        return ~s[15:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // fsm, one verdict held while its packet drains
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        S_IDLE,
        S_DRAIN
    } state_e;

    state_e     state;
    verdict_t   vd;
    // beat index within the packet, parks at 2 past the ttl beat
    logic [1:0] beat_idx;
    logic       pkt_end;
    logic       keep_pkt;

    assign beat_rd_en    = (state == S_DRAIN) && !beat_empty;
    assign pkt_end       = beat_rd_en && beat_rd_data.last;
    // next verdict may be taken on the last beat of the current packet
    assign verdict_rd_en = !verdict_empty && (state == S_IDLE || pkt_end);
    assign keep_pkt      = (vd.kind == V_FORWARD) || (vd.kind == V_PASS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            beat_idx <= '0;
        end else begin
            if (verdict_rd_en) begin
                state    <= S_DRAIN;
                beat_idx <= '0;
            end else begin
                if (pkt_end) begin
                    state <= S_IDLE;
                end
                if (beat_rd_en && beat_idx != 2'd2) begin
                    beat_idx <= beat_idx + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (verdict_rd_en) begin
            vd <= verdict_rd_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // beat rewrite
    ////////////////////////////////////////////////////////////////////////

    ipv4_hdr_u   old_hdr;
    ipv4_hdr_u   new_hdr;
    logic [15:0] new_csum;
    beat_t       fwd_beat;

    always_comb begin
        // only the ttl/protocol word and the checksum matter here
        old_hdr            = '0;
        old_hdr.f.ttl      = vd.old_ttl;
        old_hdr.f.protocol = beat_rd_data.data[15:8];
        old_hdr.f.checksum = vd.hdr_checksum;
        new_hdr            = old_hdr;
        new_hdr.f.ttl      = vd.old_ttl - 8'd1;
        // ttl and protocol share header word 4, w[5] in the union
        new_csum = csum_update(old_hdr.f.checksum, old_hdr.w[5], new_hdr.w[5]);

        fwd_beat = beat_rd_data;
        fwd_beat.meta.egress_port = (vd.kind == V_FORWARD) ? vd.egress_port : '0;
        // beat 1 carries header bytes 8..15
        if (vd.kind == V_FORWARD && beat_idx == 2'd1) begin
            fwd_beat.data[7:0]   = new_hdr.f.ttl;
            fwd_beat.data[23:16] = new_csum[15:8];
            fwd_beat.data[31:24] = new_csum[7:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // output register and drop pulses
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            drop_csum <= 1'b0;
            drop_ttl  <= 1'b0;
        end else begin
            out_valid <= beat_rd_en && keep_pkt;
            // one pulse per dropped packet, on its first beat
            drop_csum <= beat_rd_en && beat_idx == 2'd0 && vd.kind == V_DROP_CSUM;
            drop_ttl  <= beat_rd_en && beat_idx == 2'd0 && vd.kind == V_DROP_TTL;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_rd_en) begin
            out_beat <= fwd_beat;
        end
    end

    // drop pulse only with the packet's header beat in out_beat and out_valid low
    assert property (@(posedge clk) disable iff (!arst_n)
        (drop_csum || drop_ttl) |-> !out_valid && out_beat.data[7:0] == 8'h45);

endmodule

/* router_pipeline.sv */
// top level: extractor, beat and verdict buffers, forwarder
`timescale 1ns/1ns
`include "router_defs.svh"

module router_pipeline import router_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  in_valid,
    input  beat_t in_beat,
    output logic  out_valid,
    output beat_t out_beat,
    output logic  drop_csum,
    output logic  drop_ttl,
    output logic  overflow
);

    // extractor side
    logic     beat_wr_en;
    beat_t    beat_wr_data;
    logic     verdict_wr_en;
    verdict_t verdict_wr_data;

    // forwarder side
    logic     beat_rd_en;
    beat_t    beat_rd_data;
    logic     beat_empty;
    logic     beat_overflow;
    logic     verdict_rd_en;
    verdict_t verdict_rd_data;
    logic     verdict_empty;
    logic     verdict_overflow;

    ipv4_header_extract u_extract (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_valid        (in_valid),
        .in_beat         (in_beat),
        .beat_wr_en      (beat_wr_en),
        .beat_wr_data    (beat_wr_data),
        .verdict_wr_en   (verdict_wr_en),
        .verdict_wr_data (verdict_wr_data)
    );

    // holds beats until the verdict for their packet is ready
    beat_fifo #(
        .WIDTH ($bits(beat_t)),
        .DEPTH (`ROUTER_BEAT_DEPTH)
    ) u_beat_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (beat_wr_en),
        .wr_data  (beat_wr_data),
        .rd_en    (beat_rd_en),
        .rd_data  (beat_rd_data),
        .empty    (beat_empty),
        .full     (),
        .overflow (beat_overflow)
    );

    beat_fifo #(
        .WIDTH ($bits(verdict_t)),
        .DEPTH (`ROUTER_VERDICT_DEPTH)
    ) u_verdict_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (verdict_wr_en),
        .wr_data  (verdict_wr_data),
        .rd_en    (verdict_rd_en),
        .rd_data  (verdict_rd_data),
        .empty    (verdict_empty),
        .full     (),
        .overflow (verdict_overflow)
    );

    ipv4_forward u_forward (
        .clk             (clk),
        .arst_n          (arst_n),
        .beat_rd_data    (beat_rd_data),
        .beat_empty      (beat_empty),
        .verdict_rd_data (verdict_rd_data),
        .verdict_empty   (verdict_empty),
        .beat_rd_en      (beat_rd_en),
        .verdict_rd_en   (verdict_rd_en),
        .out_valid       (out_valid),
        .out_beat        (out_beat),
        .drop_csum       (drop_csum),
        .drop_ttl        (drop_ttl)
    );

    // either buffer losing a write is reported
    assign overflow = beat_overflow | verdict_overflow;

endmodule

/* tb_router_pipeline.sv */
// testbench: packet table, reference model, output monitor and watchdog
`timescale 1ns/1ns
`include "router_defs.svh"

module tb_router_pipeline import router_pkg::*; ();

    // one row of the stimulus table
    typedef struct packed {
        logic [3:0]  version;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] dst_addr;
        logic        bad_csum;
        port_t       ingress;
        logic [15:0] nbytes;
        verdict_e    kind;
    } pkt_case_t;

    logic  clk;
    logic  arst_n;
    logic  in_valid;
    beat_t in_beat;
    logic  out_valid;
    beat_t out_beat;
    logic  drop_csum;
    logic  drop_ttl;
    logic  overflow;

    pkt_case_t  cases[$];
    string      names[$];
    logic [7:0] pkt_bytes[$];
    beat_t      drive_q[$];
    beat_t      exp_q[$];
    string      exp_name[$];
    logic [31:0] lfsr;
    int table_beats;
    int exp_csum;
    int exp_ttl;
    int csum_seen;
    int ttl_seen;
    int errors;

    router_pipeline DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .drop_csum (drop_csum),
        .drop_ttl  (drop_ttl),
        .overflow  (overflow)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        errors = errors + 1;
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    // galois lfsr, one step per payload bit
    function automatic logic [7:0] rand_byte();
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    // ones' complement sum of the ten header words
    function automatic logic [15:0] fold_words(ipv4_hdr_u h);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + h.w[i];
        end
        while (acc[31:16] != 0) begin
            acc = acc[15:0] + acc[31:16];
        end
        return acc[15:0];
    endfunction

    // beat b of pkt_bytes, byte 0 in the low bits
    function automatic beat_t make_beat(int b, meta_t meta);
        beat_t bt;
        bt = '0;
        for (int k = 0; k < `ROUTER_BEAT_BYTES; k++) begin
            if (8 * b + k < pkt_bytes.size()) begin
                bt.data[8 * k +: 8] = pkt_bytes[8 * b + k];
                bt.keep[k]          = 1'b1;
            end
        end
        bt.last = (8 * b + 8 >= pkt_bytes.size());
        bt.meta = meta;
        return bt;
    endfunction

    task automatic add_case(string name, pkt_case_t c);
        names.push_back(name);
        cases.push_back(c);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_case(int idx);
        pkt_case_t     c;
        ipv4_hdr_u     h;
        ipv4_hdr_u     e;
        logic [159:0]  hb;
        verdict_e      kind;
        meta_t         meta;
        int            nbeats;
        c = cases[idx];
        h = '0;
        h.f.version   = c.version;
        h.f.ihl       = 4'd5;
        h.f.total_len = c.nbytes;
        h.f.ident     = 16'(idx);
        h.f.ttl       = c.ttl;
        h.f.protocol  = c.protocol;
        h.f.src_addr  = 32'hc0a8_0101;
        h.f.dst_addr  = c.dst_addr;
        h.f.checksum  = ~fold_words(h);
        if (c.bad_csum) begin
            h.f.checksum = h.f.checksum ^ 16'h0100;
        end
        hb = h;
        pkt_bytes.delete();
        for (int k = 0; k < 20; k++) begin
            pkt_bytes.push_back(hb[159 - 8 * k -: 8]);
        end
        while (pkt_bytes.size() < c.nbytes) begin
            pkt_bytes.push_back(rand_byte());
        end
        while (pkt_bytes.size() > c.nbytes) begin
            void'(pkt_bytes.pop_back());
        end
        nbeats = (c.nbytes + 7) / 8;
        // classify from the header rules
        if (nbeats < 3 || h.f.version != 4'd4 || h.f.ihl != 4'd5) begin
            kind = V_PASS;
        end else if (fold_words(h) != 16'hffff) begin
            kind = V_DROP_CSUM;
        end else if (h.f.ttl < 8'd2) begin
            kind = V_DROP_TTL;
        end else begin
            kind = V_FORWARD;
        end
        assert (kind == c.kind) else begin
            $display("table row %s does not agree with its own header", names[idx]);
            abort_run();
        end
        meta.ingress_port = c.ingress;
        meta.egress_port  = '0;
        for (int b = 0; b < nbeats; b++) begin
            drive_q.push_back(make_beat(b, meta));
        end
        table_beats += nbeats;
        if (kind == V_DROP_CSUM) begin
            exp_csum++;
        end
        if (kind == V_DROP_TTL) begin
            exp_ttl++;
        end
        if (kind == V_FORWARD) begin
            // full recomputation over the new header
            e            = h;
            e.f.ttl      = h.f.ttl - 8'd1;
            e.f.checksum = '0;
            e.f.checksum = ~fold_words(e);
            pkt_bytes[8]  = e.f.ttl;
            pkt_bytes[10] = e.f.checksum[15:8];
            pkt_bytes[11] = e.f.checksum[7:0];
            meta.egress_port = c.dst_addr[`ROUTER_PORT_BITS-1:0];
        end
        if (kind == V_FORWARD || kind == V_PASS) begin
            for (int b = 0; b < nbeats; b++) begin
                exp_q.push_back(make_beat(b, meta));
                exp_name.push_back(names[idx]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitor and watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (arst_n) begin
            assert (!overflow) else begin
                $display("CHECK FAILED overflow: expected 0 actual %0b", overflow);
                abort_run();
            end
            if (drop_csum) begin
                csum_seen++;
            end
            if (drop_ttl) begin
                ttl_seen++;
            end
            if (out_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("output beat %h arrived with no beat left to expect", out_beat);
                    abort_run();
                end
                assert (out_beat === exp_q[0]) else begin
                    $display("CHECK FAILED %s: expected %h actual %h",
                             exp_name[0], exp_q[0], out_beat);
                    abort_run();
                end
                void'(exp_q.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    // 40 cycles per table beat plus reset and margin
    initial begin
        wait (table_beats != 0);
        repeat (40 * table_beats + 8 + 100) @(posedge clk);
        $display("watchdog expired with %0d output beats still expected", exp_q.size());
        abort_run();
    end

    ////////////////////////////////////////////////////////////////////////////
    // table and main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_beat     = '0;
        lfsr        = 32'hee3e_e769;
        table_beats = 0;
        exp_csum    = 0;
        exp_ttl     = 0;
        csum_seen   = 0;
        ttl_seen    = 0;
        errors      = 0;

        add_case("fwd_ttl64",
                 '{4'd4, 8'd64, 8'd17, 32'h0a01_0207, 1'b0, 2'd1, 16'd60, V_FORWARD});
        add_case("bad_checksum",
                 '{4'd4, 8'd64, 8'd6, 32'h0a01_0205, 1'b1, 2'd2, 16'd40, V_DROP_CSUM});
        add_case("ttl_one",
                 '{4'd4, 8'd1, 8'd17, 32'h0a01_0206, 1'b0, 2'd0, 16'd28, V_DROP_TTL});
        add_case("ttl_zero",
                 '{4'd4, 8'd0, 8'd6, 32'h0a01_0201, 1'b0, 2'd3, 16'd33, V_DROP_TTL});
        add_case("ipv6_pass",
                 '{4'd6, 8'd64, 8'd17, 32'h0a01_0203, 1'b0, 2'd1, 16'd48, V_PASS});
        add_case("short_two_beat",
                 '{4'd4, 8'd64, 8'd17, 32'h0a01_0202, 1'b0, 2'd2, 16'd16, V_PASS});
        add_case("fwd_header_only",
                 '{4'd4, 8'd2, 8'd1, 32'h0a01_020e, 1'b0, 2'd3, 16'd20, V_FORWARD});
        add_case("fwd_ttl255",
                 '{4'd4, 8'd255, 8'd6, 32'hc0a8_0001, 1'b0, 2'd0, 16'd21, V_FORWARD});
        add_case("short_one_beat",
                 '{4'd4, 8'd64, 8'd17, 32'h0a01_0204, 1'b0, 2'd1, 16'd5, V_PASS});
        // longer than the beat buffer
        add_case("long_burst",
                 '{4'd4, 8'd128, 8'd17, 32'h0a01_020a, 1'b0, 2'd2,
                   16'(8 * (`ROUTER_BEAT_DEPTH + 9)), V_FORWARD});
        for (int i = 0; i < cases.size(); i++) begin
            build_case(i);
        end

        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;

        // whole table back to back, one beat per cycle
        foreach (drive_q[i]) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            in_beat  = drive_q[i];
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_beat  = '0;

        while (exp_q.size() != 0 || csum_seen != exp_csum || ttl_seen != exp_ttl) begin
            @(negedge clk);
        end
        // quiet period catches stray beats or pulses
        repeat (20) @(negedge clk);
        assert (csum_seen == exp_csum) else begin
            $display("CHECK FAILED drop_csum count: expected %0d actual %0d",
                     exp_csum, csum_seen);
            abort_run();
        end
        assert (ttl_seen == exp_ttl) else begin
            $display("CHECK FAILED drop_ttl count: expected %0d actual %0d",
                     exp_ttl, ttl_seen);
            abort_run();
        end
        if (errors == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

/* tb.f */
+incdir+.
router_pkg.sv
ipv4_header_extract.sv
beat_fifo.sv
ipv4_forward.sv
router_pipeline.sv
tb_router_pipeline.sv

/* Bender.yml */
package:
  name: router_pipeline

export_include_dirs:
  - .

sources:
  - router_pkg.sv
  - ipv4_header_extract.sv
  - beat_fifo.sv
  - ipv4_forward.sv
  - router_pipeline.sv
  - target: test
    files:
      - tb_router_pipeline.sv
